// ==== design/bus_pkg.sv ====
package bus_pkg;

    localparam int ADDR_W     = 14;
    localparam int DATA_W     = 8;
    localparam int SEL_W      = 2;
    localparam int OFFSET_W   = 12;
    localparam int NUM_SLAVES = 3;

    // full bus address, slave select on top of the word offset
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [SEL_W-1:0]    slave_sel_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // one beat as presented by a master
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        logic  write;
    } bus_req_t;

    function automatic slave_sel_t addr_slave(addr_t addr);
        return addr[ADDR_W-1 -: SEL_W];
    endfunction

    function automatic offset_t addr_offset(addr_t addr);
        return addr[OFFSET_W-1:0];
    endfunction

endpackage

// ==== design/scenario_pkg.sv ====
package scenario_pkg;

    import bus_pkg::*;

    typedef logic [3:0] scenario_t;
    typedef logic [2:0] beats_t;

    // odd codes write and even codes read
    localparam scenario_t SCEN_M1_WR_S0       = 4'd1;
    localparam scenario_t SCEN_M1_RD_S0       = 4'd2;
    localparam scenario_t SCEN_M1_WR_S1       = 4'd3;
    localparam scenario_t SCEN_M1_RD_S1       = 4'd4;
    localparam scenario_t SCEN_M2_WR_S2       = 4'd5;
    localparam scenario_t SCEN_M2_RD_S2       = 4'd6;
    localparam scenario_t SCEN_BOTH_WR_S1     = 4'd7;
    localparam scenario_t SCEN_BOTH_RD_S1     = 4'd8;
    localparam scenario_t SCEN_M1_BURST_WR_S0 = 4'd9;
    localparam scenario_t SCEN_M2_BURST_RD_S0 = 4'd10;

    typedef struct packed {
        logic       write;
        slave_sel_t slave;
        offset_t    offset;
        data_t      data;
        beats_t     beats;
    } master_cmd_t;

    typedef struct packed {
        scenario_t scenario;
        data_t     data1;
        data_t     data2;
        offset_t   offset;
    } scen_req_t;

    typedef struct packed {
        scenario_t scenario;
        data_t     rdata1;
        data_t     rdata2;
    } scen_res_t;

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_issue,
        ctrl_wait,
        ctrl_report
    } ctrl_state_t;

endpackage

// ==== design/bus_slave.sv ====
`timescale 1ns/10ps

module bus_slave
    import bus_pkg::*;
#(
    parameter int MEM_DEPTH = 64
) (
    input  logic    clk,
    input  logic    sel,
    input  logic    wr,
    input  offset_t addr,
    input  data_t   wdata,
    output data_t   rdata
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    data_t             mem [MEM_DEPTH];
    logic [IDX_W-1:0]  idx;

    // offsets wrap at the memory size
    assign idx = addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (sel) begin
            if (wr) begin
                mem[idx] <= wdata;
            end else begin
                rdata <= mem[idx];
            end
        end
    end

endmodule

// ==== design/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter
    import bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  bus_req_t               m1_req,
    input  logic                   m1_req_valid,
    output logic                   m1_req_ready,
    input  bus_req_t               m2_req,
    input  logic                   m2_req_valid,
    output logic                   m2_req_ready,
    output logic                   m1_rvalid,
    output logic                   m2_rvalid,
    output data_t                  m_rdata,
    output logic [NUM_SLAVES-1:0]  s_sel,
    output logic                   s_wr,
    output offset_t                s_addr,
    output data_t                  s_wdata,
    input  data_t [NUM_SLAVES-1:0] s_rdata
);

    logic       last_m2;
    logic       grant_any;
    bus_req_t   win;
    slave_sel_t win_slave;
    logic       rd_pend;
    logic       rd_owner;
    slave_sel_t rd_slave;

    // on a tie the master that lost last time goes first
    assign m1_req_ready = m1_req_valid && (!m2_req_valid || last_m2);
    assign m2_req_ready = m2_req_valid && (!m1_req_valid || !last_m2);
    assign grant_any    = m1_req_ready || m2_req_ready;
    assign win          = m2_req_ready ? m2_req : m1_req;
    assign win_slave    = addr_slave(win.addr);

    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            s_sel[i] = grant_any && (win_slave == slave_sel_t'(i));
        end
    end

    assign s_wr    = win.write;
    assign s_addr  = addr_offset(win.addr);
    assign s_wdata = win.wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_m2 <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            if (grant_any) begin
                last_m2 <= m2_req_ready;
            end
            // unmapped beats never return data
            rd_pend <= grant_any && !win.write && (win_slave < NUM_SLAVES);
        end
    end

    always_ff @(posedge clk) begin
        rd_owner <= m2_req_ready;
        rd_slave <= win_slave;
    end

    assign m1_rvalid = rd_pend && !rd_owner;
    assign m2_rvalid = rd_pend && rd_owner;
    assign m_rdata   = (rd_slave < NUM_SLAVES) ? s_rdata[rd_slave] : '0;

endmodule

// ==== design/bus_master.sv ====
`timescale 1ns/10ps

module bus_master
    import bus_pkg::*;
    import scenario_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  master_cmd_t cmd,
    input  logic        cmd_valid,
    output logic        cmd_ready,
    output bus_req_t    req,
    output logic        req_valid,
    input  logic        req_ready,
    input  logic        rvalid,
    input  data_t       rdata,
    output logic        done,
    output data_t       done_rdata
);

    logic   busy;
    logic   write_q;
    addr_t  addr_q;
    data_t  data_q;
    beats_t beats_left;
    beats_t in_flight;
    logic   cmd_acc;
    logic   beat_acc;

    assign cmd_ready = !busy;
    assign cmd_acc   = cmd_valid && cmd_ready;
    assign req_valid = busy && (beats_left != '0);
    assign beat_acc  = req_valid && req_ready;
    assign req       = '{addr: addr_q, wdata: data_q, write: write_q};

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            beats_left <= '0;
            in_flight  <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            if (cmd_acc) begin
                busy       <= 1'b1;
                beats_left <= cmd.beats;
                in_flight  <= '0;
            end else if (busy) begin
                if (beat_acc) begin
                    beats_left <= beats_left - 1'b1;
                end
                // reads outstanding at the arbiter
                in_flight <= in_flight + beats_t'(beat_acc && !write_q) - beats_t'(rvalid);
                if (write_q && beat_acc && beats_left == beats_t'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
                if (!write_q && rvalid && beats_left == '0 && in_flight == beats_t'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_acc) begin
            write_q    <= cmd.write;
            addr_q     <= {cmd.slave, cmd.offset};
            data_q     <= cmd.data;
            done_rdata <= '0;
        end else begin
            if (beat_acc) begin
                // stay inside the same slave
                addr_q[OFFSET_W-1:0] <= addr_offset(addr_q) + 1'b1;
                if (write_q) begin
                    data_q <= data_q + 1'b1;
                end
            end
            if (rvalid) begin
                done_rdata <= rdata;
            end
        end
    end

endmodule

// ==== design/scenario_controller.sv ====
`timescale 1ns/10ps

module scenario_controller
    import bus_pkg::*;
    import scenario_pkg::*;
#(
    parameter int BURST_LEN = 5
) (
    input  logic        clk,
    input  logic        reset,
    input  scen_req_t   scen_req,
    input  logic        scen_valid,
    output logic        scen_ready,
    output scen_res_t   res,
    output logic        res_valid,
    input  logic        res_ready,
    output master_cmd_t m1_cmd,
    output logic        m1_cmd_valid,
    input  logic        m1_cmd_ready,
    input  logic        m1_done,
    input  data_t       m1_rdata,
    output master_cmd_t m2_cmd,
    output logic        m2_cmd_valid,
    input  logic        m2_cmd_ready,
    input  logic        m2_done,
    input  data_t       m2_rdata
);

    ctrl_state_t state;
    scenario_t   scen_q;
    data_t       rdata1_q;
    data_t       rdata2_q;
    master_cmd_t m1_dec;
    master_cmd_t m2_dec;
    logic        m1_use;
    logic        m2_use;
    logic        m1_pend;
    logic        m2_pend;
    logic        accept;

    assign scen_ready = (state == ctrl_idle);
    assign res_valid  = (state == ctrl_report);
    assign accept     = scen_ready && scen_valid;
    assign res        = '{scenario: scen_q, rdata1: rdata1_q, rdata2: rdata2_q};

    // scenario to per-master command
    always_comb begin
        m1_use        = 1'b0;
        m2_use        = 1'b0;
        m1_dec.write  = scen_req.scenario[0];
        m1_dec.slave  = slave_sel_t'(0);
        m1_dec.offset = scen_req.offset;
        m1_dec.data   = scen_req.data1;
        m1_dec.beats  = beats_t'(1);
        m2_dec.write  = scen_req.scenario[0];
        m2_dec.slave  = slave_sel_t'(0);
        m2_dec.offset = scen_req.offset;
        m2_dec.data   = scen_req.data2;
        m2_dec.beats  = beats_t'(1);
        case (scen_req.scenario)
            SCEN_M1_WR_S0, SCEN_M1_RD_S0: begin
                m1_use = 1'b1;
            end
            SCEN_M1_WR_S1, SCEN_M1_RD_S1: begin
                m1_use       = 1'b1;
                m1_dec.slave = slave_sel_t'(1);
            end
            SCEN_M2_WR_S2, SCEN_M2_RD_S2: begin
                m2_use       = 1'b1;
                m2_dec.slave = slave_sel_t'(2);
            end
            SCEN_BOTH_WR_S1: begin
                m1_use        = 1'b1;
                m2_use        = 1'b1;
                m1_dec.slave  = slave_sel_t'(1);
                m2_dec.slave  = slave_sel_t'(1);
                m2_dec.offset = scen_req.offset + 1'b1;
            end
            SCEN_BOTH_RD_S1: begin
                m1_use        = 1'b1;
                m2_use        = 1'b1;
                m1_dec.slave  = slave_sel_t'(1);
                m2_dec.slave  = slave_sel_t'(1);
                m1_dec.offset = scen_req.offset + 1'b1;
            end
            SCEN_M1_BURST_WR_S0: begin
                m1_use       = 1'b1;
                m1_dec.beats = beats_t'(BURST_LEN);
            end
            SCEN_M2_BURST_RD_S0: begin
                m2_use       = 1'b1;
                m2_dec.beats = beats_t'(BURST_LEN);
            end
            default: begin
                // unknown code, no master used
                m1_use = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ctrl_idle;
            m1_cmd_valid <= 1'b0;
            m2_cmd_valid <= 1'b0;
            m1_pend      <= 1'b0;
            m2_pend      <= 1'b0;
        end else begin
            case (state)
                ctrl_idle: begin
                    if (accept) begin
                        state        <= ctrl_issue;
                        m1_cmd_valid <= m1_use;
                        m2_cmd_valid <= m2_use;
                        m1_pend      <= m1_use;
                        m2_pend      <= m2_use;
                    end
                end
                ctrl_issue: begin
                    if (m1_cmd_ready) begin
                        m1_cmd_valid <= 1'b0;
                    end
                    if (m2_cmd_ready) begin
                        m2_cmd_valid <= 1'b0;
                    end
                    if ((!m1_cmd_valid || m1_cmd_ready) && (!m2_cmd_valid || m2_cmd_ready)) begin
                        state <= ctrl_wait;
                    end
                end
                ctrl_wait: begin
                    // both masters must have finished
                    if ((!m1_pend || m1_done) && (!m2_pend || m2_done)) begin
                        state <= ctrl_report;
                    end
                end
                ctrl_report: begin
                    if (res_ready) begin
                        state <= ctrl_idle;
                    end
                end
                default: state <= ctrl_idle;
            endcase
            if (m1_done) begin
                m1_pend <= 1'b0;
            end
            if (m2_done) begin
                m2_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            scen_q   <= scen_req.scenario;
            m1_cmd   <= m1_dec;
            m2_cmd   <= m2_dec;
            rdata1_q <= '0;
            rdata2_q <= '0;
        end
        if (m1_done && !m1_cmd.write) begin
            rdata1_q <= m1_rdata;
        end
        if (m2_done && !m2_cmd.write) begin
            rdata2_q <= m2_rdata;
        end
    end

endmodule

// ==== design/bus_system_top.sv ====
`timescale 1ns/10ps

module bus_system_top
    import bus_pkg::*;
    import scenario_pkg::*;
#(
    parameter int BURST_LEN = 5,
    parameter int MEM_DEPTH = 64
) (
    input  logic      clk,
    input  logic      reset,
    input  scen_req_t scen_req,
    input  logic      scen_valid,
    output logic      scen_ready,
    output scen_res_t res,
    output logic      res_valid,
    input  logic      res_ready
);

    master_cmd_t            m1_cmd;
    master_cmd_t            m2_cmd;
    logic                   m1_cmd_valid;
    logic                   m2_cmd_valid;
    logic                   m1_cmd_ready;
    logic                   m2_cmd_ready;
    logic                   m1_done;
    logic                   m2_done;
    data_t                  m1_done_rdata;
    data_t                  m2_done_rdata;
    bus_req_t               m1_req;
    bus_req_t               m2_req;
    logic                   m1_req_valid;
    logic                   m2_req_valid;
    logic                   m1_req_ready;
    logic                   m2_req_ready;
    logic                   m1_rvalid;
    logic                   m2_rvalid;
    data_t                  m_rdata;
    logic [NUM_SLAVES-1:0]  s_sel;
    logic                   s_wr;
    offset_t                s_addr;
    data_t                  s_wdata;
    data_t [NUM_SLAVES-1:0] s_rdata;

    scenario_controller #(
        .BURST_LEN (BURST_LEN)
    ) u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .scen_req     (scen_req),
        .scen_valid   (scen_valid),
        .scen_ready   (scen_ready),
        .res          (res),
        .res_valid    (res_valid),
        .res_ready    (res_ready),
        .m1_cmd       (m1_cmd),
        .m1_cmd_valid (m1_cmd_valid),
        .m1_cmd_ready (m1_cmd_ready),
        .m1_done      (m1_done),
        .m1_rdata     (m1_done_rdata),
        .m2_cmd       (m2_cmd),
        .m2_cmd_valid (m2_cmd_valid),
        .m2_cmd_ready (m2_cmd_ready),
        .m2_done      (m2_done),
        .m2_rdata     (m2_done_rdata)
    );

    bus_master u_master1 (
        .clk        (clk),
        .reset      (reset),
        .cmd        (m1_cmd),
        .cmd_valid  (m1_cmd_valid),
        .cmd_ready  (m1_cmd_ready),
        .req        (m1_req),
        .req_valid  (m1_req_valid),
        .req_ready  (m1_req_ready),
        .rvalid     (m1_rvalid),
        .rdata      (m_rdata),
        .done       (m1_done),
        .done_rdata (m1_done_rdata)
    );

    bus_master u_master2 (
        .clk        (clk),
        .reset      (reset),
        .cmd        (m2_cmd),
        .cmd_valid  (m2_cmd_valid),
        .cmd_ready  (m2_cmd_ready),
        .req        (m2_req),
        .req_valid  (m2_req_valid),
        .req_ready  (m2_req_ready),
        .rvalid     (m2_rvalid),
        .rdata      (m_rdata),
        .done       (m2_done),
        .done_rdata (m2_done_rdata)
    );

    bus_arbiter u_arbiter (
        .clk          (clk),
        .reset        (reset),
        .m1_req       (m1_req),
        .m1_req_valid (m1_req_valid),
        .m1_req_ready (m1_req_ready),
        .m2_req       (m2_req),
        .m2_req_valid (m2_req_valid),
        .m2_req_ready (m2_req_ready),
        .m1_rvalid    (m1_rvalid),
        .m2_rvalid    (m2_rvalid),
        .m_rdata      (m_rdata),
        .s_sel        (s_sel),
        .s_wr         (s_wr),
        .s_addr       (s_addr),
        .s_wdata      (s_wdata),
        .s_rdata      (s_rdata)
    );

    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave
        bus_slave #(
            .MEM_DEPTH (MEM_DEPTH)
        ) u_slave (
            .clk   (clk),
            .sel   (s_sel[i]),
            .wr    (s_wr),
            .addr  (s_addr),
            .wdata (s_wdata),
            .rdata (s_rdata[i])
        );
    end

endmodule

// ==== dv/bus_system_tb.sv ====
`timescale 1ns/10ps

module bus_system_tb
    import bus_pkg::*;
    import scenario_pkg::*;
();

    localparam int BURST_LEN    = 5;
    localparam int MEM_DEPTH    = 64;
    localparam int TIMEOUT      = 500;
    localparam int RANDOM_COUNT = 200;

    logic      clk;
    logic      reset;
    scen_req_t scen_req;
    logic      scen_valid;
    logic      scen_ready;
    scen_res_t res;
    logic      res_valid;
    logic      res_ready;

    logic [15:0] lfsr_state;
    // reference copy of the three slave memories
    data_t       model_mem [NUM_SLAVES][MEM_DEPTH];
    int          stall_left;
    int          scen_count;

    bus_system_top #(
        .BURST_LEN (BURST_LEN),
        .MEM_DEPTH (MEM_DEPTH)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .scen_req   (scen_req),
        .scen_valid (scen_valid),
        .scen_ready (scen_ready),
        .res        (res),
        .res_valid  (res_valid),
        .res_ready  (res_ready)
    );

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error at time %0t: %s is %0h, expected %0h", $time, name, got, expected);
            $display("TESTS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure at time %0t: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic apply_model(input scen_req_t r, output scen_res_t e);
        int off;
        off = int'(r.offset);
        e = '{scenario: r.scenario, rdata1: '0, rdata2: '0};
        case (r.scenario)
            SCEN_M1_WR_S0: model_mem[0][off % MEM_DEPTH] = r.data1;
            SCEN_M1_RD_S0: e.rdata1 = model_mem[0][off % MEM_DEPTH];
            SCEN_M1_WR_S1: model_mem[1][off % MEM_DEPTH] = r.data1;
            SCEN_M1_RD_S1: e.rdata1 = model_mem[1][off % MEM_DEPTH];
            SCEN_M2_WR_S2: model_mem[2][off % MEM_DEPTH] = r.data2;
            SCEN_M2_RD_S2: e.rdata2 = model_mem[2][off % MEM_DEPTH];
            SCEN_BOTH_WR_S1: begin
                model_mem[1][off % MEM_DEPTH]       = r.data1;
                model_mem[1][(off + 1) % MEM_DEPTH] = r.data2;
            end
            SCEN_BOTH_RD_S1: begin
                e.rdata1 = model_mem[1][(off + 1) % MEM_DEPTH];
                e.rdata2 = model_mem[1][off % MEM_DEPTH];
            end
            SCEN_M1_BURST_WR_S0: begin
                for (int i = 0; i < BURST_LEN; i++) begin
                    model_mem[0][(off + i) % MEM_DEPTH] = data_t'(r.data1 + i);
                end
            end
            SCEN_M2_BURST_RD_S0: e.rdata2 = model_mem[0][(off + BURST_LEN - 1) % MEM_DEPTH];
            default: ;
        endcase
    endtask

    task automatic send_scenario(input scen_req_t r);
        int cycles;
        cycles = 0;
        scen_req   <= r;
        scen_valid <= 1'b1;
        do begin
            @(posedge clk);
            // no result may appear before this request is taken
            check_value("res_valid", 32'(res_valid), 32'd0);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("timeout while waiting for scen_ready");
            end
        end while (!scen_ready);
        scen_valid <= 1'b0;
    endtask

    task automatic collect_result(input scen_res_t exp);
        int          cycles;
        logic        held;
        logic        got;
        scen_res_t   held_res;
        logic [31:0] v;
        cycles   = 0;
        held     = 1'b0;
        got      = 1'b0;
        held_res = '0;
        while (!got) begin
            @(posedge clk);
            cycles++;
            if (res_valid) begin
                check_value("scen_ready", 32'(scen_ready), 32'd0);
                if (held) begin
                    check_value("res", 32'(res), 32'(held_res));
                end
                if (res_ready) begin
                    check_value("res.scenario", 32'(res.scenario), 32'(exp.scenario));
                    check_value("res.rdata1", 32'(res.rdata1), 32'(exp.rdata1));
                    check_value("res.rdata2", 32'(res.rdata2), 32'(exp.rdata2));
                    got = 1'b1;
                end else begin
                    held     = 1'b1;
                    held_res = res;
                end
            end else if (held) begin
                report_failure("res_valid dropped before the result was taken");
            end
            if (cycles > TIMEOUT) begin
                report_failure("timeout while waiting for res_valid");
            end
            if (stall_left > 0) begin
                stall_left--;
                res_ready <= 1'b0;
            end else begin
                // low about one cycle in four
                draw_bits(2, v);
                res_ready <= (v[1:0] != 2'd0);
            end
        end
    endtask

    task automatic run_scenario(input scen_req_t r);
        scen_res_t exp;
        apply_model(r, exp);
        send_scenario(r);
        collect_result(exp);
        scen_count++;
    endtask

    task automatic make_request(input scenario_t code, input int off, output scen_req_t r);
        logic [31:0] v;
        r.scenario = code;
        draw_bits(8, v);
        r.data1 = v[7:0];
        draw_bits(8, v);
        r.data2 = v[7:0];
        r.offset = offset_t'(off);
    endtask

    task automatic draw_offset(output int off);
        logic [31:0] v;
        draw_bits(8, v);
        off = int'(v[7:0]) % (MEM_DEPTH - BURST_LEN);
    endtask

    task automatic write_then_read(input scenario_t wr_code, input int off);
        scen_req_t r;
        make_request(wr_code, off, r);
        run_scenario(r);
        make_request(scenario_t'(wr_code + 1), off, r);
        run_scenario(r);
    endtask

    initial begin
        scen_req_t   r;
        int          off;
        logic [31:0] v;
        scenario_t   code;
        clk        = 1'b0;
        reset      = 1'b1;
        scen_req   = '0;
        scen_valid = 1'b0;
        res_ready  = 1'b0;
        lfsr_state = 16'd78;
        stall_left = 0;
        scen_count = 0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("res_valid", 32'(res_valid), 32'd0);
        check_value("scen_ready", 32'(scen_ready), 32'd1);

        // single transfers, one pair per slave
        for (int s = 0; s < NUM_SLAVES; s++) begin
            draw_offset(off);
            write_then_read(scenario_t'(1 + 2 * s), off);
        end

        // both masters on slave 1
        draw_offset(off);
        write_then_read(SCEN_BOTH_WR_S1, off);

        // burst write, burst read, then every burst word alone
        draw_offset(off);
        write_then_read(SCEN_M1_BURST_WR_S0, off);
        for (int i = 0; i < BURST_LEN; i++) begin
            make_request(SCEN_M1_RD_S0, off + i, r);
            run_scenario(r);
        end

        // long result stalls
        for (int i = 0; i < 3; i++) begin
            stall_left = 12;
            draw_offset(off);
            write_then_read(SCEN_M2_WR_S2, off);
        end

        scen_count = 0;
        while (scen_count < RANDOM_COUNT) begin
            draw_bits(4, v);
            code = v[3:0];
            draw_offset(off);
            // reads get a fresh write of the same region first
            if (code >= 4'd1 && code <= 4'd10 && !code[0]) begin
                make_request(scenario_t'(code - 1), off, r);
                run_scenario(r);
            end
            make_request(code, off, r);
            run_scenario(r);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== filelist.f ====
design/bus_pkg.sv
design/scenario_pkg.sv
design/bus_slave.sv
design/bus_arbiter.sv
design/bus_master.sv
design/scenario_controller.sv
design/bus_system_top.sv
dv/bus_system_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f --top-module bus_system_tb
./obj_dir/Vbus_system_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log || ! grep -q "TESTS PASSED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
